// ==== Bender.yml ====
package:
  name: peripheral_soc

sources:
  - verilog/soc_pkg.sv
  - verilog/reset_stretch.sv
  - verilog/bus_decode.sv
  - verilog/word_ram.sv
  - verilog/io_page.sv
  - verilog/uart_tx.sv
  - verilog/peripheral_soc.sv
  - target: test
    files:
      - testbench/tb_peripheral_soc.sv

// ==== tb.f ====
verilog/soc_pkg.sv
verilog/reset_stretch.sv
verilog/bus_decode.sv
verilog/word_ram.sv
verilog/io_page.sv
verilog/uart_tx.sv
verilog/peripheral_soc.sv
testbench/tb_peripheral_soc.sv

// ==== testbench/tb_peripheral_soc.sv ====
// ------------------------------
// Directed testbench for the SoC memory and peripheral side
// ------------------------------
module tb_peripheral_soc;
  import soc_pkg::*;

  localparam int ram_words    = 1536;
  localparam int clks_per_bit = 16;
  localparam int gpio_width   = 24;
  localparam int cycle_limit  = 6000;  // ~276 reset + 640 UART + 300 bus, with margin
  localparam logic [3:0] legal_masks [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                             4'b0011, 4'b1100, 4'b1111};

  logic                  clk;
  logic                  reset_button;
  mem_req_t              mem_req;
  mem_rsp_t              mem_rsp;
  logic [4:0]            leds;
  logic [gpio_width-1:0] gpio_out;
  logic [gpio_width-1:0] gpio_oe;
  logic [gpio_width-1:0] gpio_in;
  logic                  txd;

  logic [31:0] rng_state;
  int          cycles;
  int          check_count;
  int          err_count;
  logic [31:0] leds_exp;  // Last IO values, reused by the unmapped test
  logic [31:0] out_exp;
  logic [31:0] dir_exp;

  peripheral_soc #(
    .ram_words(ram_words), .clks_per_bit(clks_per_bit), .gpio_width(gpio_width)
  ) UUT (
    .clk, .reset_button, .mem_req, .mem_rsp,
    .leds, .gpio_out, .gpio_oe, .gpio_in, .txd
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a handshake or frame never finished", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return rng_state;
  endfunction

  function automatic logic [23:0] ram_addr(input int idx);
    return {2'b00, 20'(idx), 2'b00};
  endfunction

  function automatic logic [23:0] io_addr(input int sel);
    return {2'b01, 20'd1 << sel, 2'b00};  // One-hot word select
  endfunction

  // Expected RAM word after a masked write
  function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bits(input string name, input logic [gpio_width-1:0] got,
                            input logic [gpio_width-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int checks_before, input int errs_before);
    $display("%s: %0d checks, %0d errors", name, check_count - checks_before,
             err_count - errs_before);
  endtask

  // Hold the write until wbusy drops, count stalled cycles
  task automatic bus_write(input logic [23:0] addr, input logic [31:0] data,
                           input logic [3:0] mask, output int stalls);
    @(negedge clk);
    mem_req.addr  = addr;
    mem_req.wdata = data;
    mem_req.wmask = mask;
    mem_req.rstrb = 1'b0;
    stalls = 0;
    #1;  // Let wbusy settle
    while (mem_rsp.wbusy) begin
      @(negedge clk);
      #1;
      stalls++;
    end
    @(negedge clk);  // Taken at the edge in between
    mem_req.wmask = 4'b0000;
  endtask

  task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
    @(negedge clk);
    mem_req.addr  = addr;
    mem_req.wmask = 4'b0000;
    mem_req.rstrb = 1'b1;
    @(negedge clk);
    mem_req.rstrb = 1'b0;
    while (mem_rsp.rbusy) @(negedge clk);
    data = mem_rsp.rdata;
  endtask

  // Mid-bit sampling of one 8N1 frame
  task automatic uart_capture(output logic [7:0] data, output logic start_bit,
                              output logic stop_bit);
    @(negedge clk);
    while (txd) @(negedge clk);  // Start edge
    repeat (clks_per_bit / 2 - 1) @(negedge clk);
    start_bit = txd;
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = txd;  // LSB first
    end
    repeat (clks_per_bit) @(negedge clk);
    stop_bit = txd;
  endtask

  task automatic ram_byte_masks();
    logic [31:0] model [32];
    logic [31:0] data;
    logic [31:0] rd;
    int          stalls;
    int          c0;
    int          e0;
    c0 = check_count;
    e0 = err_count;
    for (int i = 0; i < 32; i++) begin
      data = next_random();
      model[i] = data;
      bus_write(ram_addr(i), data, 4'b1111, stalls);
    end
    for (int i = 0; i < 32; i++) begin
      data = next_random();
      bus_write(ram_addr(i), data, legal_masks[i % 7], stalls);
      model[i] = byte_merge(model[i], data, legal_masks[i % 7]);
    end
    data = next_random();
    bus_write(ram_addr(ram_words + 3), data, 4'b1111, stalls);  // Wraps to word 3
    model[3] = data;
    for (int i = 0; i < 32; i++) begin
      bus_read(ram_addr(i), rd);
      check_word($sformatf("ram[%0d]", i), rd, model[i]);
    end
    report_test("ram byte masks", c0, e0);
  endtask

  task automatic io_register_access();
    logic [31:0] rd;
    logic [31:0] pins;
    int          stalls;
    int          c0;
    int          e0;
    c0 = check_count;
    e0 = err_count;
    leds_exp = next_random();
    out_exp  = next_random();
    dir_exp  = next_random();
    bus_write(io_addr(io_leds_bit), leds_exp, 4'b1111, stalls);
    check_bits("leds", gpio_width'(leds), gpio_width'(leds_exp[4:0]));
    bus_write(io_addr(io_port_out_bit), out_exp, 4'b1111, stalls);
    check_bits("gpio_out", gpio_out, out_exp[gpio_width-1:0]);
    bus_write(io_addr(io_port_dir_bit), dir_exp, 4'b1111, stalls);
    check_bits("gpio_oe", gpio_oe, dir_exp[gpio_width-1:0]);
    bus_read(io_addr(io_leds_bit), rd);
    check_word("leds readback", rd, {27'd0, leds_exp[4:0]});
    bus_read(io_addr(io_port_out_bit), rd);
    check_word("port_out readback", rd, {8'd0, out_exp[gpio_width-1:0]});
    bus_read(io_addr(io_port_dir_bit), rd);
    check_word("port_dir readback", rd, {8'd0, dir_exp[gpio_width-1:0]});
    pins = next_random();
    @(negedge clk);
    gpio_in = pins[gpio_width-1:0];
    bus_read(io_addr(io_port_in_bit), rd);
    check_word("port_in", rd, {8'd0, pins[gpio_width-1:0]});
    report_test("io registers", c0, e0);
  endtask

  task automatic uart_single_frame();
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;
    logic        start_bit;
    logic        stop_bit;
    logic [31:0] stat;
    logic [31:0] stat_dat;
    int          stalls;
    int          c0;
    int          e0;
    c0 = check_count;
    e0 = err_count;
    tx_byte = next_random();
    fork
      uart_capture(rx_byte, start_bit, stop_bit);
      begin
        bus_write(io_addr(io_uart_dat_bit), {24'd0, tx_byte}, 4'b1111, stalls);
        bus_read(io_addr(io_uart_cntl_bit), stat);
        bus_read(io_addr(io_uart_dat_bit), stat_dat);
      end
    join
    check_word("uart idle write stalls", 32'(stalls), 32'd0);
    check_word("uart_cntl busy", stat, 32'd1 << uart_busy_pos);
    check_word("uart_dat busy", stat_dat, 32'd1 << uart_busy_pos);
    check_bits("txd start bit", gpio_width'(start_bit), '0);
    check_byte("txd data", rx_byte, tx_byte);
    check_bits("txd stop bit", gpio_width'(stop_bit), gpio_width'(1));
    repeat (clks_per_bit) @(negedge clk);  // Past the end of the stop bit
    bus_read(io_addr(io_uart_cntl_bit), stat);
    check_word("uart_cntl idle", stat, 32'd0);
    report_test("uart frame", c0, e0);
  endtask

  task automatic uart_back_pressure();
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] rx0;
    logic [7:0] rx1;
    logic       st0;
    logic       sp0;
    logic       st1;
    logic       sp1;
    int         stalls0;
    int         stalls1;
    int         c0;
    int         e0;
    c0 = check_count;
    e0 = err_count;
    b0 = next_random();
    b1 = next_random();
    fork
      begin
        uart_capture(rx0, st0, sp0);
        uart_capture(rx1, st1, sp1);
      end
      begin
        bus_write(io_addr(io_uart_dat_bit), {24'd0, b0}, 4'b1111, stalls0);
        bus_write(io_addr(io_uart_dat_bit), {24'd0, b1}, 4'b1111, stalls1);
      end
    join
    check_word("first write stalls", 32'(stalls0), 32'd0);
    // Second write starts a cycle after the first acceptance, frame is 10 bits
    check_word("second write stalls", 32'(stalls1), 32'(10 * clks_per_bit - 1));
    check_byte("first byte", rx0, b0);
    check_byte("second byte", rx1, b1);
    check_bits("framing bits", gpio_width'({st0, sp0, st1, sp1}), gpio_width'(4'b0101));
    report_test("uart back-pressure", c0, e0);
  endtask

  task automatic unmapped_pages();
    logic [31:0] ram_val;
    logic [31:0] rd;
    logic [19:0] low;
    int          stalls;
    int          c0;
    int          e0;
    c0 = check_count;
    e0 = err_count;
    low = 20'h00031;  // RAM word 49, also hits leds, port_out, port_dir
    ram_val = next_random();
    bus_write({2'b00, low, 2'b00}, ram_val, 4'b1111, stalls);
    bus_read({2'b10, low, 2'b00}, rd);
    check_word("flash page read", rd, 32'd0);
    bus_read({2'b11, low, 2'b00}, rd);
    check_word("page 11 read", rd, 32'd0);
    bus_write({2'b10, low, 2'b00}, 32'hffff_ffff, 4'b1111, stalls);
    bus_write({2'b11, low, 2'b00}, 32'h0000_0000, 4'b1111, stalls);
    bus_read({2'b00, low, 2'b00}, rd);
    check_word("ram[49] after unmapped writes", rd, ram_val);
    check_bits("leds unchanged", gpio_width'(leds), gpio_width'(leds_exp[4:0]));
    check_bits("gpio_out unchanged", gpio_out, out_exp[gpio_width-1:0]);
    check_bits("gpio_oe unchanged", gpio_oe, dir_exp[gpio_width-1:0]);
    report_test("unmapped pages", c0, e0);
  endtask

  initial begin
    reset_button = 1'b0;
    mem_req      = '0;
    gpio_in      = '0;
    rng_state    = 32'h3022e7b0;
    cycles       = 0;
    check_count  = 0;
    err_count    = 0;
    repeat (8) @(negedge clk);
    // Write to leds, uart_dat, port_out and port_dir while held in reset
    mem_req.addr  = {2'b01, 20'h00033, 2'b00};
    mem_req.wdata = 32'hffff_ffff;
    mem_req.wmask = 4'b1111;
    repeat (8) @(negedge clk);
    check_bits("leds in reset", gpio_width'(leds), '0);
    check_bits("gpio_out in reset", gpio_out, '0);
    check_bits("gpio_oe in reset", gpio_oe, '0);
    check_bits("txd and wbusy in reset", gpio_width'({txd, mem_rsp.wbusy}), gpio_width'(2'b10));
    reset_button = 1'b1;
    mem_req.addr = io_addr(io_leds_bit);  // LED write held across the stretch
    repeat (255) @(negedge clk);
    check_bits("leds during stretch", gpio_width'(leds), '0);
    @(negedge clk);  // Write lands once the internal reset is high
    check_bits("leds after stretch", gpio_width'(leds), gpio_width'(5'h1f));
    mem_req = '0;
    repeat (4) @(negedge clk);
    report_test("reset", 0, 0);
    ram_byte_masks();
    io_register_access();
    uart_single_frame();
    uart_back_pressure();
    unmapped_pages();
    $display("Done: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/bus_decode.sv ====
// ------------------------------
// Bus decoder, RAM and IO pages with read mux
// ------------------------------
module bus_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  soc_pkg::mem_req_t mem_req,
  output soc_pkg::mem_rsp_t mem_rsp,
  output soc_pkg::mem_req_t ram_req,
  input  logic [31:0]       ram_rdata,
  output soc_pkg::io_req_t  io_req,
  input  soc_pkg::mem_rsp_t io_rsp
);
  import soc_pkg::*;

  page_t page;     // Page of the current request
  page_t rd_page;  // Page of the outstanding read
  logic  wstrb;

  assign page  = page_t'(mem_req.addr[23:22]);
  assign wstrb = |mem_req.wmask;  // Write implied by mask

  // RAM side, writes only land on the RAM page
  assign ram_req.addr  = mem_req.addr;
  assign ram_req.wdata = mem_req.wdata;
  assign ram_req.wmask = (page == page_ram) ? mem_req.wmask : 4'b0000;
  assign ram_req.rstrb = mem_req.rstrb && (page == page_ram);

  // IO side
  assign io_req.word_address = mem_req.addr[21:2];  // Word offset in page
  assign io_req.wdata        = mem_req.wdata;
  assign io_req.wstrb        = wstrb && (page == page_io);
  assign io_req.rstrb        = mem_req.rstrb && (page == page_io);

  // Latch page at the strobe, RAM data arrives a cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_page <= page_none;
    end else if (mem_req.rstrb) begin
      rd_page <= page;
    end
  end

  always_comb begin
    unique case (rd_page)
      page_ram: mem_rsp.rdata = ram_rdata;
      page_io:  mem_rsp.rdata = io_rsp.rdata;  // Combinational from held addr
      default:  mem_rsp.rdata = 32'd0;         // Flash and hole read zero
    endcase
  end

  // Only the IO page can stall
  assign mem_rsp.rbusy = io_rsp.rbusy;
  assign mem_rsp.wbusy = io_rsp.wbusy;

  // Master only issues byte, halfword or word masks
  a_wmask_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_req.wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                          4'b0011, 4'b1100, 4'b1111}
  ) else $error("illegal wmask %b", mem_req.wmask);

endmodule

// ==== verilog/io_page.sv ====
// ------------------------------
// IO page, LEDs, GPIO and UART registers
// ------------------------------
module io_page #(
  parameter int gpio_width = 24
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  soc_pkg::io_req_t      req,
  output soc_pkg::mem_rsp_t     rsp,
  output logic [4:0]            leds,
  output logic [gpio_width-1:0] gpio_out,
  output logic [gpio_width-1:0] gpio_oe,
  input  logic [gpio_width-1:0] gpio_in,
  output logic                  tx_start,
  output logic [7:0]            tx_data,
  input  logic                  tx_busy
);
  import soc_pkg::*;

  logic        uart_wr;    // Data write pending
  logic [31:0] uart_stat;  // Status word for both UART selects
  logic [31:0] rd_mux;

  // Register writes, upper bits of wdata dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      leds     <= '0;
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else if (req.wstrb) begin
      if (req.word_address[io_leds_bit])     leds     <= req.wdata[4:0];
      if (req.word_address[io_port_out_bit]) gpio_out <= req.wdata[gpio_width-1:0];
      if (req.word_address[io_port_dir_bit]) gpio_oe  <= req.wdata[gpio_width-1:0];
    end
  end

  always_comb begin
    uart_stat                 = 32'd0;
    uart_stat[uart_busy_pos]  = tx_busy;
    uart_stat[uart_valid_pos] = 1'b0;  // No receiver fitted
  end

  // One-hot selects, OR of all sources
  always_comb begin
    rd_mux = 32'd0;
    if (req.word_address[io_leds_bit])      rd_mux |= 32'(leds);
    if (req.word_address[io_uart_dat_bit])  rd_mux |= uart_stat;
    if (req.word_address[io_uart_cntl_bit]) rd_mux |= uart_stat;
    if (req.word_address[io_port_in_bit])   rd_mux |= 32'(gpio_in);
    if (req.word_address[io_port_out_bit])  rd_mux |= 32'(gpio_out);
    if (req.word_address[io_port_dir_bit])  rd_mux |= 32'(gpio_oe);
  end

  // Hold off the master while a frame is in flight
  assign uart_wr  = req.wstrb && req.word_address[io_uart_dat_bit];
  assign tx_start = uart_wr && !tx_busy;  // Accepted this edge
  assign tx_data  = req.wdata[7:0];

  assign rsp.rdata = rd_mux;
  assign rsp.rbusy = 1'b0;  // Reads never stall
  assign rsp.wbusy = uart_wr && tx_busy;

  // Stalled write stays on the bus with the same data
  a_wbusy_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp.wbusy |-> req.wstrb ##1 (req.wstrb && $stable(req.wdata))
  ) else $error("write dropped while wbusy");

endmodule

// ==== verilog/peripheral_soc.sv ====
// ------------------------------
// SoC memory and peripheral subsystem top
// ------------------------------
module peripheral_soc #(
  parameter int ram_words    = 1536,
  parameter int clks_per_bit = 416,  // 48 MHz at 115200 baud
  parameter int gpio_width   = 24
) (
  input  logic                  clk,
  input  logic                  reset_button,
  input  soc_pkg::mem_req_t     mem_req,
  output soc_pkg::mem_rsp_t     mem_rsp,
  output logic [4:0]            leds,
  output logic [gpio_width-1:0] gpio_out,
  output logic [gpio_width-1:0] gpio_oe,
  input  logic [gpio_width-1:0] gpio_in,
  output logic                  txd
);
  import soc_pkg::*;

  logic        rst_n;
  mem_req_t    ram_req;
  logic [31:0] ram_rdata;
  io_req_t     io_req;
  mem_rsp_t    io_rsp;
  logic        tx_start;
  logic [7:0]  tx_data;
  logic        tx_busy;

  reset_stretch u_reset (.clk, .reset_button, .rst_n);

  bus_decode u_decode (
    .clk, .rst_n, .mem_req, .mem_rsp,
    .ram_req, .ram_rdata, .io_req, .io_rsp
  );

  word_ram #(.ram_words(ram_words)) u_ram (
    .clk, .req(ram_req), .rdata(ram_rdata)
  );

  io_page #(.gpio_width(gpio_width)) u_io (
    .clk, .rst_n, .req(io_req), .rsp(io_rsp),
    .leds, .gpio_out, .gpio_oe, .gpio_in,
    .tx_start, .tx_data, .tx_busy
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
    .clk, .rst_n, .start(tx_start), .data(tx_data),
    .busy(tx_busy), .txd
  );

endmodule

// ==== verilog/reset_stretch.sv ====
// ------------------------------
// Reset stretcher, 255 cycles after button release
// ------------------------------
module reset_stretch (
  input  logic clk,
  input  logic reset_button,  // Active low, asynchronous
  output logic rst_n
);

  logic [7:0] cnt;

  // Saturating counter, cleared while the button is held
  always_ff @(posedge clk or negedge reset_button) begin
    if (!reset_button) begin
      cnt <= '0;
    end else if (!rst_n) begin
      cnt <= cnt + 8'd1;
    end
  end

  // Release only when all ones
  assign rst_n = &cnt;

endmodule

// ==== verilog/soc_pkg.sv ====
// ------------------------------
// SoC bus types, page codes and IO register map
// ------------------------------
package soc_pkg;

  // Master request on the processor memory bus
  typedef struct packed {
    logic [23:0] addr;   // Byte address, bits 1:0 ignored
    logic [31:0] wdata;
    logic [3:0]  wmask;  // Nonzero means write
    logic        rstrb;  // One-cycle read pulse
  } mem_req_t;

  // Slave response
  typedef struct packed {
    logic [31:0] rdata;
    logic        rbusy;
    logic        wbusy;
  } mem_rsp_t;

  // Request into the IO page
  typedef struct packed {
    logic [19:0] word_address;  // One-hot register select
    logic [31:0] wdata;
    logic        wstrb;
    logic        rstrb;
  } io_req_t;

  // Memory map from addr[23:22]
  typedef enum logic [1:0] {
    page_ram   = 2'b00,
    page_io    = 2'b01,
    page_flash = 2'b10,  // Not populated, reads zero
    page_none  = 2'b11
  } page_t;

  // One-hot IO select positions
  localparam int io_leds_bit      = 0;  // RW leds
  localparam int io_uart_dat_bit  = 1;  // W tx byte, R status
  localparam int io_uart_cntl_bit = 2;  // R status
  localparam int io_port_in_bit   = 3;  // R gpio inputs
  localparam int io_port_out_bit  = 4;  // RW gpio output values
  localparam int io_port_dir_bit  = 5;  // RW gpio output enables

  // UART status word
  localparam int uart_valid_pos = 8;  // Rx byte waiting
  localparam int uart_busy_pos  = 9;  // Tx frame in flight

endpackage

// ==== verilog/uart_tx.sv ====
// ------------------------------
// UART transmitter, 8N1
// ------------------------------
module uart_tx #(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,  // Single-cycle request
  input  logic [7:0] data,
  output logic       busy,
  output logic       txd
);

  localparam int cw = $clog2(clks_per_bit);

  logic [cw-1:0] clk_cnt;  // Position inside a bit
  logic [3:0]    bit_cnt;  // Bits sent, 0 to 9
  logic [9:0]    shift;    // Stop, data, start

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shift   <= '1;  // Line idles high
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
        shift   <= {1'b1, data, 1'b0};  // Latch frame
      end
    end else if (clk_cnt == cw'(clks_per_bit - 1)) begin
      clk_cnt <= '0;
      shift   <= {1'b1, shift[9:1]};  // Next bit, refill with ones
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // Stop bit done
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + cw'(1);
    end
  end

  assign txd = shift[0];

  // Shift register back to all ones once the frame ends
  a_idle_high : assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> txd
  ) else $error("txd low while idle");

endmodule

// ==== verilog/word_ram.sv ====
// ------------------------------
// Word RAM, byte-lane writes, registered read
// ------------------------------
module word_ram #(
  parameter int ram_words = 1536
) (
  input  logic              clk,
  input  soc_pkg::mem_req_t req,
  output logic [31:0]       rdata
);

  localparam int aw = $clog2(ram_words);

  logic [31:0]   mem [ram_words];
  logic [aw-1:0] idx;

  // Word index, wraps past the top word
  assign idx = aw'(req.addr[21:2] % ram_words);

  always_ff @(posedge clk) begin
    // Byte lanes under the mask
    for (int b = 0; b < 4; b++) begin
      if (req.wmask[b]) begin
        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
    rdata <= mem[idx];  // Read every cycle, old data on collision
  end

endmodule
